// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_wb_backend
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= wb_backend.f
VFLAGS    ?= --binary --timing --assert

SIM_BIN  = $(BUILD_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the pass line must be there and the fail line must not
run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file import wb_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     csr_re,
    input  csr_num_t csr_num,
    output word_t    csr_rvalue,
    input  logic     csr_we,
    input  word_t    csr_wmask,
    input  word_t    csr_wvalue
);

    word_t crmd;
    word_t prmd;
    word_t ecfg;
    word_t era;
    word_t save0;
    word_t save1;
    word_t save2;
    word_t save3;
    word_t rdata;

    // replace only the bits allowed by both the instruction and the register
    function automatic word_t merge(input word_t old_value, input word_t reg_wmask);
        word_t m;
        m = csr_wmask & reg_wmask;
        return (old_value & ~m) | (csr_wvalue & m);
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd <= CRMD_RESET;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd <= merge(crmd, CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd <= '0;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd <= merge(prmd, PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg <= '0;
        end else if (csr_we && csr_num == CSR_ECFG) begin
            ecfg <= merge(ecfg, ECFG_WMASK);
        end
    end

    // era and the save registers are fully writable
    always_ff @(posedge clk) begin
        if (!resetn) begin
            era   <= '0;
            save0 <= '0;
            save1 <= '0;
            save2 <= '0;
            save3 <= '0;
        end else if (csr_we) begin
            if (csr_num == CSR_ERA) begin
                era <= merge(era, FULL_WMASK);
            end
            if (csr_num == CSR_SAVE0) begin
                save0 <= merge(save0, FULL_WMASK);
            end
            if (csr_num == CSR_SAVE1) begin
                save1 <= merge(save1, FULL_WMASK);
            end
            if (csr_num == CSR_SAVE2) begin
                save2 <= merge(save2, FULL_WMASK);
            end
            if (csr_num == CSR_SAVE3) begin
                save3 <= merge(save3, FULL_WMASK);
            end
        end
    end

    // read side, unknown numbers give zero
    always_comb begin
        case (csr_num)
            CSR_CRMD:  rdata = crmd;
            CSR_PRMD:  rdata = prmd;
            CSR_ECFG:  rdata = ecfg;
            CSR_ERA:   rdata = era;
            CSR_SAVE0: rdata = save0;
            CSR_SAVE1: rdata = save1;
            CSR_SAVE2: rdata = save2;
            CSR_SAVE3: rdata = save3;
            default:   rdata = '0;
        endcase
    end

    // old value in the write cycle, which gives the swap
    assign csr_rvalue = csr_re ? rdata : '0;

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import wb_pkg::*; (
    input  logic      clk,
    // write port
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    // read ports
    input  reg_addr_t rf_raddr1,
    output word_t     rf_rdata1,
    input  reg_addr_t rf_raddr2,
    output word_t     rf_rdata2
);

    // r0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rf_we && rf_waddr != 5'd0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // asynchronous reads, no write bypass
    assign rf_rdata1 = (rf_raddr1 == 5'd0) ? '0 : regs[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == 5'd0) ? '0 : regs[rf_raddr2];

endmodule

// ==== rtl/wb_backend.sv ====
`timescale 1ns/1ps

module wb_backend import wb_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    // memory stage side
    output logic       wb_allowin,
    input  logic       mem_to_wb_valid,
    input  logic       mem_rf_we,
    input  reg_addr_t  mem_rf_waddr,
    input  word_t      mem_rf_wdata,
    input  pc_t        mem_pc,
    input  logic       mem_csr_re,
    input  logic       mem_csr_we,
    input  csr_num_t   mem_csr_num,
    input  word_t      mem_csr_wmask,
    // commit trace
    output pc_t        debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata,
    // write-back bus for decode forwarding
    output logic       wb_fwd_we,
    output reg_addr_t  wb_fwd_waddr,
    output word_t      wb_fwd_wdata,
    // register read ports for decode
    input  reg_addr_t  rf_raddr1,
    output word_t      rf_rdata1,
    input  reg_addr_t  rf_raddr2,
    output word_t      rf_rdata2
);

    logic     csr_re;
    csr_num_t csr_num;
    word_t    csr_rvalue;
    logic     csr_we;
    word_t    csr_wmask;
    word_t    csr_wvalue;

    // the forwarding bus is the register file write port itself
    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .wb_allowin        (wb_allowin),
        .mem_to_wb_valid   (mem_to_wb_valid),
        .mem_rf_we         (mem_rf_we),
        .mem_rf_waddr      (mem_rf_waddr),
        .mem_rf_wdata      (mem_rf_wdata),
        .mem_pc            (mem_pc),
        .mem_csr_re        (mem_csr_re),
        .mem_csr_we        (mem_csr_we),
        .mem_csr_num       (mem_csr_num),
        .mem_csr_wmask     (mem_csr_wmask),
        .csr_re            (csr_re),
        .csr_num           (csr_num),
        .csr_rvalue        (csr_rvalue),
        .csr_we            (csr_we),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .rf_we             (wb_fwd_we),
        .rf_waddr          (wb_fwd_waddr),
        .rf_wdata          (wb_fwd_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .csr_re     (csr_re),
        .csr_num    (csr_num),
        .csr_rvalue (csr_rvalue),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rf_we     (wb_fwd_we),
        .rf_waddr  (wb_fwd_waddr),
        .rf_wdata  (wb_fwd_wdata),
        .rf_raddr1 (rf_raddr1),
        .rf_rdata1 (rf_rdata1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata2 (rf_rdata2)
    );

endmodule

// ==== rtl/wb_pkg.sv ====
package wb_pkg;

    // widths fixed by the instruction set
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;

    // implemented csr numbers
    localparam csr_num_t CSR_CRMD  = 14'h0;
    localparam csr_num_t CSR_PRMD  = 14'h1;
    localparam csr_num_t CSR_ECFG  = 14'h4;
    localparam csr_num_t CSR_ERA   = 14'h6;
    localparam csr_num_t CSR_SAVE0 = 14'h30;
    localparam csr_num_t CSR_SAVE1 = 14'h31;
    localparam csr_num_t CSR_SAVE2 = 14'h32;
    localparam csr_num_t CSR_SAVE3 = 14'h33;

    // crmd comes up in direct address mode, everything else resets to zero
    localparam word_t CRMD_RESET = 32'h0000_0008;

    // writable bits per csr
    // crmd: plv, ie, da, pg, datf, datm
    localparam word_t CRMD_WMASK = 32'h0000_01ff;
    // prmd: pplv, pie
    localparam word_t PRMD_WMASK = 32'h0000_0007;
    // ecfg: local interrupt enables
    localparam word_t ECFG_WMASK = 32'h0000_1fff;
    // era and save0..3 are plain 32-bit storage
    localparam word_t FULL_WMASK = 32'hffff_ffff;

endpackage

// ==== rtl/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage import wb_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    // handshake from the memory stage
    output logic      wb_allowin,
    input  logic      mem_to_wb_valid,
    input  logic      mem_rf_we,
    input  reg_addr_t mem_rf_waddr,
    input  word_t     mem_rf_wdata,
    input  pc_t       mem_pc,
    input  logic      mem_csr_re,
    input  logic      mem_csr_we,
    input  csr_num_t  mem_csr_num,
    input  word_t     mem_csr_wmask,
    // csr file request
    output logic      csr_re,
    output csr_num_t  csr_num,
    input  word_t     csr_rvalue,
    output logic      csr_we,
    output word_t     csr_wmask,
    output word_t     csr_wvalue,
    // register file write port
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    // commit trace
    output pc_t       debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    logic      wb_ready_go;
    logic      wb_valid;
    logic      wb_rf_we;
    reg_addr_t wb_rf_waddr;
    word_t     wb_rf_wdata;
    pc_t       wb_pc;
    logic      wb_csr_re;
    logic      wb_csr_we;
    csr_num_t  wb_csr_num;
    word_t     wb_csr_wmask;
    word_t     final_wdata;

    // last stage, nothing downstream can stall it
    assign wb_ready_go = 1'b1;
    assign wb_allowin  = ~wb_valid | wb_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    // fields only move on an accepted instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_rf_we     <= 1'b0;
            wb_rf_waddr  <= '0;
            wb_rf_wdata  <= '0;
            wb_pc        <= '0;
            wb_csr_re    <= 1'b0;
            wb_csr_we    <= 1'b0;
            wb_csr_num   <= '0;
            wb_csr_wmask <= '0;
        end else if (mem_to_wb_valid && wb_allowin) begin
            wb_rf_we     <= mem_rf_we;
            wb_rf_waddr  <= mem_rf_waddr;
            wb_rf_wdata  <= mem_rf_wdata;
            wb_pc        <= mem_pc;
            wb_csr_re    <= mem_csr_re;
            wb_csr_we    <= mem_csr_we;
            wb_csr_num   <= mem_csr_num;
            wb_csr_wmask <= mem_csr_wmask;
        end
    end

    // csr instructions return the old csr value
    assign final_wdata = wb_csr_re ? csr_rvalue : wb_rf_wdata;

    assign csr_re     = wb_csr_re;
    assign csr_num    = wb_csr_num;
    assign csr_we     = wb_csr_we & wb_valid;
    assign csr_wmask  = wb_csr_wmask;
    assign csr_wvalue = wb_rf_wdata;

    assign rf_we    = wb_rf_we & wb_valid;
    assign rf_waddr = wb_rf_waddr;
    assign rf_wdata = final_wdata;

    // trace must stay quiet when the stage holds a bubble
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_rf_waddr;
    assign debug_wb_rf_wdata = final_wdata;

endmodule

// ==== sim/tb_wb_backend.sv ====
`timescale 1ns/1ps

module tb_wb_backend import wb_pkg::*; ();

    localparam int WAIT_LIMIT = 20;
    localparam int NUM_ROWS   = 15;
    localparam int NUM_RANDOM = 200;

    // one retiring instruction with the trace wdata it should produce
    typedef struct packed {
        logic      valid;
        logic      rf_we;
        reg_addr_t waddr;
        word_t     wdata;
        pc_t       pc;
        logic      csr_re;
        logic      csr_we;
        csr_num_t  csr_num;
        word_t     wmask;
        word_t     exp_wdata;
    } entry_t;

    logic       clk;
    logic       resetn;
    logic       mem_to_wb_valid;
    logic       mem_rf_we;
    reg_addr_t  mem_rf_waddr;
    word_t      mem_rf_wdata;
    pc_t        mem_pc;
    logic       mem_csr_re;
    logic       mem_csr_we;
    csr_num_t   mem_csr_num;
    word_t      mem_csr_wmask;
    reg_addr_t  rf_raddr1;
    reg_addr_t  rf_raddr2;
    logic       wb_allowin;
    pc_t        debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;
    logic       wb_fwd_we;
    reg_addr_t  wb_fwd_waddr;
    word_t      wb_fwd_wdata;
    word_t      rf_rdata1;
    word_t      rf_rdata2;

    // shadow of the register file and the eight csrs
    word_t      shadow_rf [0:31];
    logic       written [0:31];
    word_t      shadow_csr [0:7];
    reg_addr_t  last_waddr;
    entry_t     pending;
    logic       table_phase;
    integer     seed;

    csr_num_t csr_pick [0:7] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ERA,
                                 CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};

    // valid, rf_we, waddr, wdata, pc, csr_re, csr_we, csr_num, wmask, trace wdata
    entry_t stim [0:NUM_ROWS-1] = '{
        // plain writes, a bubble and a write to r0
        '{1'b1, 1'b1, 5'd1, 32'h12345678, 32'h100, 1'b0, 1'b0, CSR_CRMD, 32'h0, 32'h12345678},
        '{1'b0, 1'b0, 5'd0, 32'h0, 32'h0, 1'b0, 1'b0, CSR_CRMD, 32'h0, 32'h0},
        '{1'b1, 1'b1, 5'd2, 32'hdeadbeef, 32'h104, 1'b0, 1'b0, CSR_CRMD, 32'h0, 32'hdeadbeef},
        '{1'b1, 1'b1, 5'd0, 32'h5555aaaa, 32'h108, 1'b0, 1'b0, CSR_CRMD, 32'h0, 32'h5555aaaa},
        // csrrd of crmd and of an unimplemented number
        '{1'b1, 1'b1, 5'd3, 32'h0, 32'h10c, 1'b1, 1'b0, CSR_CRMD, 32'h0, 32'h8},
        '{1'b1, 1'b1, 5'd4, 32'h0, 32'h110, 1'b1, 1'b0, 14'h7, 32'h0, 32'h0},
        // csrwr returns the old save1, the later csrrd the new one
        '{1'b1, 1'b1, 5'd5, 32'hcafef00d, 32'h114, 1'b1, 1'b1, CSR_SAVE1, 32'hffffffff, 32'h0},
        '{1'b0, 1'b0, 5'd0, 32'h0, 32'h0, 1'b0, 1'b0, CSR_CRMD, 32'h0, 32'h0},
        '{1'b1, 1'b1, 5'd6, 32'h0, 32'h118, 1'b1, 1'b0, CSR_SAVE1, 32'h0, 32'hcafef00d},
        // csrxchg on prmd only reaches bits 2..0
        '{1'b1, 1'b1, 5'd7, 32'h000000ad, 32'h11c, 1'b1, 1'b1, CSR_PRMD, 32'h000000ff, 32'h0},
        '{1'b1, 1'b1, 5'd8, 32'h0, 32'h120, 1'b1, 1'b0, CSR_PRMD, 32'h0, 32'h5},
        // back to back, csrwr then csrrd of era
        '{1'b1, 1'b1, 5'd9, 32'h11112222, 32'h124, 1'b0, 1'b0, CSR_CRMD, 32'h0, 32'h11112222},
        '{1'b1, 1'b1, 5'd10, 32'h0badc0de, 32'h128, 1'b1, 1'b1, CSR_ERA, 32'hffffffff, 32'h0},
        '{1'b1, 1'b1, 5'd11, 32'h0, 32'h12c, 1'b1, 1'b0, CSR_ERA, 32'h0, 32'h0badc0de},
        '{1'b1, 1'b1, 5'd12, 32'h33334444, 32'h130, 1'b0, 1'b0, CSR_CRMD, 32'h0, 32'h33334444}
    };

    wb_backend dut0 (.*);

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping on the first error");
    endtask

    task automatic compare_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
                                        $time, name, actual, expected));
        end
    endtask

    function automatic int csr_slot(input csr_num_t num);
        for (int s = 0; s < 8; s++) begin
            if (csr_pick[s] == num) return s;
        end
        return -1;
    endfunction

    // value the instruction retires with, taken before its own csr write
    function automatic word_t model_result(input entry_t e);
        int s;
        s = csr_slot(e.csr_num);
        if (!e.csr_re) return e.wdata;
        if (s < 0) return '0;
        return shadow_csr[s];
    endfunction

    task automatic update_shadow(input entry_t e, input word_t result);
        int    s;
        word_t m;
        s = csr_slot(e.csr_num);
        if (e.rf_we && e.waddr != 5'd0) begin
            shadow_rf[e.waddr] = result;
            written[e.waddr]   = 1'b1;
        end
        if (e.csr_we && s >= 0) begin
            case (s)
                0:       m = e.wmask & CRMD_WMASK;
                1:       m = e.wmask & PRMD_WMASK;
                2:       m = e.wmask & ECFG_WMASK;
                default: m = e.wmask & FULL_WMASK;
            endcase
            shadow_csr[s] = (shadow_csr[s] & ~m) | (e.wdata & m);
        end
    endtask

    task automatic check_trace(input entry_t e);
        word_t result;
        result = model_result(e);
        if (e.valid && e.rf_we) begin
            if (table_phase) compare_value("table trace wdata", e.exp_wdata, result);
            compare_value("debug_wb_rf_we", word_t'(debug_wb_rf_we), 32'hf);
            compare_value("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum), word_t'(e.waddr));
            compare_value("debug_wb_rf_wdata", debug_wb_rf_wdata, result);
            compare_value("wb_fwd_we", word_t'(wb_fwd_we), 32'h1);
            compare_value("wb_fwd_waddr", word_t'(wb_fwd_waddr), word_t'(e.waddr));
            compare_value("wb_fwd_wdata", wb_fwd_wdata, result);
            last_waddr = e.waddr;
        end else begin
            compare_value("debug_wb_rf_we", word_t'(debug_wb_rf_we), 32'h0);
            compare_value("wb_fwd_we", word_t'(wb_fwd_we), 32'h0);
        end
        if (e.valid) begin
            compare_value("debug_wb_pc", debug_wb_pc, e.pc);
            update_shadow(e, result);
        end
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        while (wb_allowin !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n >= WAIT_LIMIT) stop_with_failure("timeout: wb_allowin never went high");
        end
    endtask

    // drive one entry, then check the trace of the entry before it
    task automatic issue(input entry_t e);
        wait_allowin();
        @(posedge clk);
        mem_to_wb_valid <= e.valid;
        mem_rf_we       <= e.rf_we;
        mem_rf_waddr    <= e.waddr;
        mem_rf_wdata    <= e.wdata;
        mem_pc          <= e.pc;
        mem_csr_re      <= e.csr_re;
        mem_csr_we      <= e.csr_we;
        mem_csr_num     <= e.csr_num;
        mem_csr_wmask   <= e.wmask;
        rf_raddr1       <= last_waddr;
        rf_raddr2       <= last_waddr;
        @(negedge clk);
        // write of the previous trace has landed
        compare_value("rf_rdata1", rf_rdata1, shadow_rf[last_waddr]);
        compare_value("rf_rdata2", rf_rdata2, shadow_rf[last_waddr]);
        check_trace(pending);
        pending = e;
    endtask

    task automatic make_random(input pc_t pc, output entry_t e);
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] m;
        r = $random(seed);
        d = $random(seed);
        m = $random(seed);
        e.valid     = 1'b1;
        e.rf_we     = (r[2:0] != 3'd0);
        e.waddr     = r[7:3];
        e.wdata     = d;
        e.pc        = pc;
        e.csr_num   = (r[13:12] != 2'd0) ? csr_pick[r[11:9]] : r[31:18];
        // op 0 none, 1 csrrd, 2 csrwr, 3 csrxchg
        e.csr_re    = (r[15:14] != 2'd0);
        e.csr_we    = r[15];
        e.wmask     = (r[15:14] == 2'd2) ? 32'hffff_ffff : m;
        e.exp_wdata = '0;
    endtask

    // port 2 trails port 1 by one register so the two decoders differ
    task automatic read_back_all();
        int k;
        int prev;
        prev = 0;
        for (k = 0; k < 32; k++) begin
            if (written[k] || k == 0) begin
                @(posedge clk);
                rf_raddr1 <= k[4:0];
                rf_raddr2 <= prev[4:0];
                @(negedge clk);
                compare_value($sformatf("rf_rdata1 of r%0d", k), rf_rdata1, shadow_rf[k]);
                compare_value($sformatf("rf_rdata2 of r%0d", prev), rf_rdata2, shadow_rf[prev]);
                prev = k;
            end
        end
    endtask

    // any failed bound assertion ends the run at once
    always @(negedge clk) begin
        if (dut0.u_checker.fail_count != 0) begin
            stop_with_failure("a concurrent assertion on the DUT failed");
        end
    end

    initial begin
        entry_t      e;
        logic [31:0] r;
        pc_t         pc;
        int          i;
        seed = 32'hac72_6de1;
        clk = 1'b0;
        resetn = 1'b0;
        mem_to_wb_valid = 1'b0;
        mem_rf_we = 1'b0;
        mem_rf_waddr = '0;
        mem_rf_wdata = '0;
        mem_pc = '0;
        mem_csr_re = 1'b0;
        mem_csr_we = 1'b0;
        mem_csr_num = '0;
        mem_csr_wmask = '0;
        rf_raddr1 = '0;
        rf_raddr2 = '0;
        for (i = 0; i < 32; i++) begin
            shadow_rf[i] = '0;
            written[i]   = 1'b0;
        end
        for (i = 0; i < 8; i++) shadow_csr[i] = '0;
        shadow_csr[0] = CRMD_RESET;
        last_waddr  = '0;
        pending     = '0;
        table_phase = 1'b1;

        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        compare_value("wb_allowin", word_t'(wb_allowin), 32'h1);
        compare_value("debug_wb_rf_we", word_t'(debug_wb_rf_we), 32'h0);
        compare_value("rf_rdata1", rf_rdata1, 32'h0);
        compare_value("rf_rdata2", rf_rdata2, 32'h0);

        for (i = 0; i < NUM_ROWS; i++) issue(stim[i]);
        issue('0);

        // random instructions with up to three bubbles in front of each
        table_phase = 1'b0;
        pc = 32'h200;
        for (i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            repeat (r[1:0]) begin
                make_random(pc, e);
                e.valid = 1'b0;
                issue(e);
            end
            make_random(pc, e);
            issue(e);
            pc = pc + 32'd4;
        end
        issue('0);
        read_back_all();

        if (dut0.u_checker.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_with_failure("a concurrent assertion on the DUT failed");
        end
    end

endmodule

// ==== sim/wb_backend_assert.sv ====
`timescale 1ns/1ps

module wb_backend_assert import wb_pkg::*; (
    input logic       clk,
    input logic       resetn,
    input logic       mem_to_wb_valid,
    input logic       wb_allowin,
    input logic [3:0] debug_wb_rf_we,
    input logic       csr_we
);

    // number of failed assertions so far
    int fail_count = 0;

    // trace byte enables are all or nothing
    trace_we_whole: assert property (@(posedge clk) disable iff (!resetn)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf)
    else begin
        $error("debug_wb_rf_we has a partial byte enable %h", debug_wb_rf_we);
        fail_count++;
    end

    // last stage never stalls
    allowin_high: assert property (@(posedge clk) disable iff (!resetn) wb_allowin)
    else begin
        $error("wb_allowin is low out of reset");
        fail_count++;
    end

    // an empty stage must not write a csr
    no_csr_write_when_empty: assert property (@(posedge clk) disable iff (!resetn)
        !(mem_to_wb_valid && wb_allowin) |=> !csr_we)
    else begin
        $error("csr_we is high after a cycle without an accepted instruction");
        fail_count++;
    end

endmodule

bind wb_backend wb_backend_assert u_checker (
    .clk             (clk),
    .resetn          (resetn),
    .mem_to_wb_valid (mem_to_wb_valid),
    .wb_allowin      (wb_allowin),
    .debug_wb_rf_we  (debug_wb_rf_we),
    .csr_we          (csr_we)
);

// ==== wb_backend.f ====
rtl/wb_pkg.sv
rtl/wb_stage.sv
rtl/csr_file.sv
rtl/reg_file.sv
rtl/wb_backend.sv
sim/wb_backend_assert.sv
sim/tb_wb_backend.sv
